//--- include/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath and register file sizes
`define WORD_WIDTH 16
`define REG_COUNT 8
`define REG_IDX_WIDTH 3

// data memory size, in words
`define DMEM_DEPTH 256

// jal and jalr write their return address here
`define LINK_REG 7

`endif

//--- source/isaPkg.sv
`include "core_defs.svh"

package isaPkg;

	// one data or address word
	typedef logic [`WORD_WIDTH-1:0] wordT;

	// register index, 8 registers
	typedef logic [`REG_IDX_WIDTH-1:0] regIdxT;

	// word index into data memory
	typedef logic [$clog2(`DMEM_DEPTH)-1:0] dmemAddrT;

	// where the writeback value comes from
	typedef enum logic [1:0] {
		WB_SRC_ALU  = 2'd0, // alu result
		WB_SRC_MEM  = 2'd1, // loaded data
		WB_SRC_LINK = 2'd2  // return address for a link
	} wbSrcT;

endpackage

//--- source/pipePkg.sv
package pipePkg;

	// memory stage controls
	typedef struct packed {
		logic memRead;
		logic memWrite;
	} memCtrlT;

	// writeback controls
	// also looked at by the hazard unit outside
	typedef struct packed {
		logic          regWrite;
		isaPkg::wbSrcT  wbSrc;
		isaPkg::regIdxT writeReg;
		logic          halt;
	} wbCtrlT;

	// execute stage output, held in the EX/MEM latch
	typedef struct packed {
		memCtrlT       mem;
		wbCtrlT        wb;
		isaPkg::wordT  aluOut;    // result, or address for loads and stores
		isaPkg::wordT  storeData;
		isaPkg::wordT  nextPC;    // pc + 2, used by a link
	} exMemT;

	// memory stage output, held in the MEM/WB latch
	typedef struct packed {
		wbCtrlT       wb;
		isaPkg::wordT aluOut;
		isaPkg::wordT readData; // 0 unless a load
		isaPkg::wordT nextPC;
	} memWbT;

endpackage

//--- source/exMemLatch.sv
`timescale 1ns/1ps

module exMemLatch (
	input  logic           clk,
	input  logic           rstN,
	input  logic           en,
	input  logic           flush,
	input  pipePkg::exMemT d,
	output pipePkg::exMemT q
);

	pipePkg::memCtrlT memQ;
	pipePkg::wbCtrlT  wbQ;
	isaPkg::wordT     aluOutQ;
	isaPkg::wordT     storeDataQ;
	isaPkg::wordT     nextPCQ;

	// control fields, a bubble has all of them at 0
	always_ff @(posedge clk) begin
		if (!rstN || flush) begin // flush wins over a stall
			memQ <= '0;
			wbQ  <= '0;
		end else if (en) begin
			memQ <= d.mem;
			wbQ  <= d.wb;
		end
	end

	// payload, only meaningful with its controls
	always_ff @(posedge clk) begin
		if (en) begin
			aluOutQ    <= d.aluOut;
			storeDataQ <= d.storeData;
			nextPCQ    <= d.nextPC;
		end
	end

	assign q = '{
		mem:       memQ,
		wb:        wbQ,
		aluOut:    aluOutQ,
		storeData: storeDataQ,
		nextPC:    nextPCQ
	};

endmodule

//--- source/memStage.sv
`timescale 1ns/1ps

`include "core_defs.svh"

module memStage (
	input  logic           clk,
	input  pipePkg::exMemT ex,
	output pipePkg::memWbT out
);

	isaPkg::wordT     dmem [`DMEM_DEPTH]; // contents survive reset
	isaPkg::dmemAddrT addr;
	isaPkg::wordT     loadWord;

	// word addressed, upper address bits ignored
	assign addr = ex.aluOut[$bits(isaPkg::dmemAddrT)-1:0];

	// store lands at the end of the cycle
	always_ff @(posedge clk) begin
		if (ex.mem.memWrite) begin
			dmem[addr] <= ex.storeData;
		end
	end

	// asynchronous read
	always_comb begin
		if (ex.mem.memRead) begin
			loadWord = dmem[addr];
		end else begin
			loadWord = '0; // keeps readData quiet for non-loads
		end
	end

	// bundle for the MEM/WB latch
	always_comb begin
		out.wb       = ex.wb;
		out.aluOut   = ex.aluOut;
		out.readData = loadWord;
		out.nextPC   = ex.nextPC;
	end

endmodule

//--- source/memWbLatch.sv
`timescale 1ns/1ps

module memWbLatch (
	input  logic           clk,
	input  logic           rstN,
	input  logic           en,
	input  logic           fetchStall,
	input  pipePkg::memWbT d,
	output pipePkg::memWbT q,
	output logic           fetchStallWb
);

	pipePkg::wbCtrlT wbQ;     // registered controls before the stall mask
	isaPkg::wordT    aluOutQ;
	isaPkg::wordT    readDataQ;
	isaPkg::wordT    nextPCQ;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			wbQ <= '0;
		end else if (en) begin
			wbQ <= d.wb;
		end
	end

	always_ff @(posedge clk) begin
		if (en) begin
			aluOutQ   <= d.aluOut;
			readDataQ <= d.readData;
			nextPCQ   <= d.nextPC;
		end
	end

	// fetch stall flag is sampled every cycle, stall or not
	always_ff @(posedge clk) begin
		if (!rstN) begin
			fetchStallWb <= 1'b0;
		end else begin
			fetchStallWb <= fetchStall;
		end
	end

	// no register write, link or halt while the pipe is held
	always_comb begin
		q.wb.writeReg = wbQ.writeReg;
		q.wb.regWrite = en & wbQ.regWrite;
		q.wb.halt     = en & wbQ.halt;
		if (en) begin
			q.wb.wbSrc = wbQ.wbSrc;
		end else begin
			q.wb.wbSrc = isaPkg::WB_SRC_ALU;
		end
		q.aluOut   = aluOutQ;
		q.readData = readDataQ;
		q.nextPC   = nextPCQ;
	end

endmodule

//--- source/regFileWb.sv
`timescale 1ns/1ps

`include "core_defs.svh"

module regFileWb (
	input  logic           clk,
	input  logic           rstN,
	input  pipePkg::memWbT wb,
	input  isaPkg::regIdxT rdAddrA,
	input  isaPkg::regIdxT rdAddrB,
	output isaPkg::wordT   rdDataA,
	output isaPkg::wordT   rdDataB
);

	isaPkg::wordT regs [`REG_COUNT];
	isaPkg::wordT wrData;
	logic         wrEn;

	assign wrEn = wb.wb.regWrite;

	// writeback mux
	always_comb begin
		case (wb.wb.wbSrc)
			isaPkg::WB_SRC_MEM:  wrData = wb.readData;
			isaPkg::WB_SRC_LINK: wrData = wb.nextPC; // jal, jalr
			default:             wrData = wb.aluOut;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wb.wb.writeReg] <= wrData;
		end
	end

	// read ports see a write in the same cycle
	always_comb begin
		if (wrEn && (rdAddrA == wb.wb.writeReg)) begin
			rdDataA = wrData;
		end else begin
			rdDataA = regs[rdAddrA];
		end
	end

	always_comb begin
		if (wrEn && (rdAddrB == wb.wb.writeReg)) begin
			rdDataB = wrData;
		end else begin
			rdDataB = regs[rdAddrB];
		end
	end

endmodule

//--- source/memBackEnd.sv
`timescale 1ns/1ps

module memBackEnd (
	input  logic            clk,
	input  logic            rstN,
	input  logic            en,         // pipeline enable, low stalls
	input  logic            flush,
	input  pipePkg::exMemT  exIn,
	input  logic            fetchStall,
	input  isaPkg::regIdxT  rdAddrA,
	input  isaPkg::regIdxT  rdAddrB,
	output isaPkg::wordT    rdDataA,
	output isaPkg::wordT    rdDataB,
	output pipePkg::wbCtrlT wbInfo,     // to the hazard unit
	output logic            halted,
	output logic            fetchStallWb
);

	pipePkg::exMemT exMemQ;
	pipePkg::memWbT memWbD;
	pipePkg::memWbT memWbQ;

	exMemLatch exMemLatch_i (
		.clk   (clk),
		.rstN  (rstN),
		.en    (en),
		.flush (flush),
		.d     (exIn),
		.q     (exMemQ)
	);

	// data memory access
	memStage memStage_i (
		.clk (clk),
		.ex  (exMemQ),
		.out (memWbD)
	);

	memWbLatch memWbLatch_i (
		.clk          (clk),
		.rstN         (rstN),
		.en           (en),
		.fetchStall   (fetchStall),
		.d            (memWbD),
		.q            (memWbQ),
		.fetchStallWb (fetchStallWb)
	);

	// writeback and register reads
	regFileWb regFileWb_i (
		.clk     (clk),
		.rstN    (rstN),
		.wb      (memWbQ),
		.rdAddrA (rdAddrA),
		.rdAddrB (rdAddrB),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB)
	);

	assign wbInfo = memWbQ.wb;
	assign halted = memWbQ.wb.halt; // already masked by en

endmodule

//--- tb/memBackEnd_chk.sv
`timescale 1ns/1ps

module memBackEnd_chk (
	input logic           clk,
	input logic           rstN,
	input logic           en,
	input logic           fetchStall,
	input pipePkg::memWbT q,
	input logic           fetchStallWb
);

	// a held pipe performs no register write and keeps what it holds
	stallNoWrite: assert property (@(posedge clk) disable iff (!rstN)
		!en |=> (!$past(q.wb.regWrite) && $stable(q.wb.writeReg) && $stable(q.aluOut)
			&& $stable(q.readData) && $stable(q.nextPC)))
		else $error("MEM/WB latch wrote or lost its contents while the pipeline is stalled");

	// reset leaves a bubble behind
	resetBubble: assert property (@(posedge clk)
		!rstN |=> (q.wb == '0))
		else $error("MEM/WB controls not cleared by reset");

	// flag runs one cycle late, stalled or not
	fetchStallDelay: assert property (@(posedge clk) disable iff (!rstN)
		$past(rstN) |-> (fetchStallWb == $past(fetchStall)))
		else $error("fetchStallWb does not follow fetchStall by one cycle");

endmodule

// every MEM/WB latch gets the checker
bind memWbLatch memBackEnd_chk memBackEnd_chk_i (
	.clk          (clk),
	.rstN         (rstN),
	.en           (en),
	.fetchStall   (fetchStall),
	.q            (q),
	.fetchStallWb (fetchStallWb)
);

//--- tb/memBackEnd_tb.sv
`timescale 1ns/1ps

`include "core_defs.svh"

module memBackEnd_tb;

	localparam int clkPeriod    = 8;
	localparam int testCycles   = 115; // all directed tests together
	localparam int marginCycles = 100;
	localparam pipePkg::exMemT bubble = '0;

	logic            clk = 1'b0;
	logic            rstN;
	logic            en;
	logic            flush;
	pipePkg::exMemT  exIn;
	logic            fetchStall;
	isaPkg::regIdxT  rdAddrA;
	isaPkg::regIdxT  rdAddrB;
	isaPkg::wordT    rdDataA;
	isaPkg::wordT    rdDataB;
	pipePkg::wbCtrlT wbInfo;
	logic            halted;
	logic            fetchStallWb;

	int           errors = 0;
	int           checks = 0;
	isaPkg::wordT shadowRegs [`REG_COUNT]; // expected register contents
	isaPkg::wordT shadowMem [`DMEM_DEPTH]; // only written slots are read

	memBackEnd memBackEnd_i (
		.clk          (clk),
		.rstN         (rstN),
		.en           (en),
		.flush        (flush),
		.exIn         (exIn),
		.fetchStall   (fetchStall),
		.rdAddrA      (rdAddrA),
		.rdAddrB      (rdAddrB),
		.rdDataA      (rdDataA),
		.rdDataB      (rdDataB),
		.wbInfo       (wbInfo),
		.halted       (halted),
		.fetchStallWb (fetchStallWb)
	);

	always #(clkPeriod / 2) clk = ~clk;

	initial begin : watchdog
		#((testCycles + marginCycles) * clkPeriod);
		$display("timeout after %0d cycles, the tests did not finish",
			testCycles + marginCycles);
		$display("tests failed");
		$finish;
	end

	function automatic isaPkg::wordT randomWord();
		logic [31:0] r;
		r = $urandom;
		return isaPkg::wordT'(r);
	endfunction

	function automatic isaPkg::regIdxT pickReg();
		logic [31:0] r;
		r = $urandom;
		return isaPkg::regIdxT'(r);
	endfunction

	// word slot, upper address bits dropped
	function automatic isaPkg::dmemAddrT memSlot(input isaPkg::wordT addr);
		return isaPkg::dmemAddrT'(addr);
	endfunction

	function automatic pipePkg::exMemT aluBundle(input isaPkg::regIdxT dest,
		input isaPkg::wordT val);
		pipePkg::exMemT b;
		b = bubble;
		b.wb.regWrite = 1'b1;
		b.wb.wbSrc    = isaPkg::WB_SRC_ALU;
		b.wb.writeReg = dest;
		b.aluOut      = val;
		b.storeData   = randomWord(); // must not reach the register
		b.nextPC      = randomWord();
		return b;
	endfunction

	function automatic pipePkg::exMemT storeBundle(input isaPkg::wordT addr,
		input isaPkg::wordT data);
		pipePkg::exMemT b;
		b = bubble;
		b.mem.memWrite = 1'b1;
		b.aluOut       = addr;
		b.storeData    = data;
		return b;
	endfunction

	function automatic pipePkg::exMemT loadBundle(input isaPkg::wordT addr,
		input isaPkg::regIdxT dest);
		pipePkg::exMemT b;
		b = bubble;
		b.mem.memRead = 1'b1;
		b.wb.regWrite = 1'b1;
		b.wb.wbSrc    = isaPkg::WB_SRC_MEM;
		b.wb.writeReg = dest;
		b.aluOut      = addr;
		b.nextPC      = randomWord();
		return b;
	endfunction

	function automatic pipePkg::exMemT linkBundle(input isaPkg::wordT pc);
		pipePkg::exMemT b;
		b = bubble;
		b.wb.regWrite = 1'b1;
		b.wb.wbSrc    = isaPkg::WB_SRC_LINK;
		b.wb.writeReg = isaPkg::regIdxT'(`LINK_REG);
		b.aluOut      = ~pc; // jump target, never written
		b.nextPC      = pc;
		return b;
	endfunction

	task automatic compareWord(input string name, input isaPkg::wordT exp,
		input isaPkg::wordT act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic compareBit(input string name, input logic exp, input logic act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
		end
	endtask

	task automatic expectPorts(input isaPkg::wordT exp);
		compareWord("rdDataA", exp, rdDataA);
		compareWord("rdDataB", exp, rdDataB);
	endtask

	// bundle enters at edge N, returns after edge N+1 with the bypass live
	task automatic runBundle(input pipePkg::exMemT b, input isaPkg::regIdxT watch);
		@(posedge clk);
		exIn    <= b;
		rdAddrA <= watch;
		rdAddrB <= watch;
		@(posedge clk); // edge N
		exIn <= bubble;
		@(negedge clk);
		expectPorts(shadowRegs[watch]); // too early to see it
		@(posedge clk);
		@(negedge clk);
		compareWord("wbInfo", isaPkg::wordT'(b.wb), isaPkg::wordT'(wbInfo));
	endtask

	task automatic verifyCommitted(input isaPkg::regIdxT idx);
		@(posedge clk); // edge N+2, write committed
		@(negedge clk);
		expectPorts(shadowRegs[idx]);
	endtask

	task automatic resetTest();
		isaPkg::regIdxT idx;
		for (int i = 0; i < `REG_COUNT; i++) begin
			idx = isaPkg::regIdxT'(i);
			@(posedge clk);
			rdAddrA <= idx;
			rdAddrB <= ~idx;
			@(negedge clk);
			compareWord("rdDataA", '0, rdDataA);
			compareWord("rdDataB", '0, rdDataB);
			compareBit("halted", 1'b0, halted);
			compareBit("fetchStallWb", 1'b0, fetchStallWb);
		end
	endtask

	task automatic aluTest();
		isaPkg::regIdxT dest;
		isaPkg::wordT   val;
		for (int n = 0; n < 8; n++) begin
			dest = pickReg();
			val  = randomWord();
			runBundle(aluBundle(dest, val), dest);
			shadowRegs[dest] = val;
			expectPorts(shadowRegs[dest]);
			verifyCommitted(dest);
		end
	endtask

	task automatic storeLoadTest();
		isaPkg::regIdxT dest;
		isaPkg::wordT   addr;
		isaPkg::wordT   data;
		for (int n = 0; n < 4; n++) begin
			dest = pickReg();
			addr = randomWord();
			data = randomWord();
			@(posedge clk);
			exIn    <= storeBundle(addr, data);
			rdAddrA <= dest;
			rdAddrB <= dest;
			shadowMem[memSlot(addr)] = data;
			if (n % 2 == 1) begin
				@(posedge clk); // store enters, one bubble follows
				exIn <= bubble;
			end
			// even passes put the load right behind the store
			addr = {~addr[15:8], addr[7:0]}; // same word, other upper byte
			runBundle(loadBundle(addr, dest), dest);
			shadowRegs[dest] = shadowMem[memSlot(addr)];
			expectPorts(shadowRegs[dest]);
			verifyCommitted(dest);
		end
	endtask

	task automatic linkTest();
		isaPkg::wordT pc;
		pc = randomWord();
		runBundle(linkBundle(pc), isaPkg::regIdxT'(`LINK_REG));
		shadowRegs[`LINK_REG] = pc;
		expectPorts(shadowRegs[`LINK_REG]);
		verifyCommitted(isaPkg::regIdxT'(`LINK_REG));
	endtask

	task automatic stallFlushTest();
		isaPkg::regIdxT dest;
		isaPkg::wordT   val;
		isaPkg::wordT   addr;
		isaPkg::wordT   keep;
		dest = pickReg();
		val  = ~shadowRegs[dest];
		@(posedge clk);
		exIn    <= aluBundle(dest, val);
		rdAddrA <= dest;
		rdAddrB <= dest;
		@(posedge clk);
		exIn <= bubble;
		@(posedge clk); // write now held in MEM/WB
		en <= 1'b0;
		repeat (3) begin
			@(negedge clk);
			expectPorts(shadowRegs[dest]);
			compareBit("wbInfo.regWrite", 1'b0, wbInfo.regWrite);
			@(posedge clk);
		end
		en <= 1'b1;
		@(negedge clk);
		shadowRegs[dest] = val; // held write completes
		expectPorts(shadowRegs[dest]);
		verifyCommitted(dest);

		// store flushed on entry
		addr = randomWord();
		keep = randomWord();
		runBundle(storeBundle(addr, keep), dest);
		shadowMem[memSlot(addr)] = keep;
		@(posedge clk);
		exIn  <= storeBundle(addr, ~keep);
		flush <= 1'b1;
		@(posedge clk);
		exIn  <= bubble;
		flush <= 1'b0;
		runBundle(loadBundle(addr, dest), dest);
		shadowRegs[dest] = shadowMem[memSlot(addr)];
		expectPorts(shadowRegs[dest]);
		verifyCommitted(dest);

		// flush of a held write, en low at the same edge
		val = ~shadowRegs[dest];
		@(posedge clk);
		exIn <= aluBundle(dest, val);
		@(posedge clk);
		exIn  <= bubble;
		en    <= 1'b0;
		flush <= 1'b1;
		@(posedge clk);
		en    <= 1'b1;
		flush <= 1'b0;
		repeat (3) begin
			@(negedge clk);
			expectPorts(shadowRegs[dest]);
			@(posedge clk);
		end
	endtask

	task automatic haltFetchTest();
		pipePkg::exMemT b;
		logic           prev;
		logic [31:0]    r;
		b         = bubble;
		b.wb.halt = 1'b1;
		@(posedge clk);
		exIn <= b;
		@(posedge clk); // edge N
		exIn <= bubble;
		@(negedge clk);
		compareBit("halted", 1'b0, halted);
		@(posedge clk);
		@(negedge clk);
		compareBit("halted", 1'b1, halted);
		@(posedge clk);
		@(negedge clk);
		compareBit("halted", 1'b0, halted);

		prev = 1'b0;
		for (int n = 0; n < 12; n++) begin
			r = $urandom;
			@(posedge clk);
			fetchStall <= r[0];
			en         <= (n < 4 || n >= 8); // four stalled cycles
			@(negedge clk);
			compareBit("fetchStallWb", prev, fetchStallWb);
			prev = r[0];
		end
		@(posedge clk);
		fetchStall <= 1'b0;
		en         <= 1'b1;
		@(negedge clk);
		compareBit("fetchStallWb", prev, fetchStallWb);
	endtask

	initial begin
		void'($urandom(32'h2ebea4e8));
		rstN       = 1'b0;
		en         = 1'b1;
		flush      = 1'b0;
		exIn       = bubble;
		fetchStall = 1'b0;
		rdAddrA    = '0;
		rdAddrB    = '0;
		for (int i = 0; i < `REG_COUNT; i++) begin
			shadowRegs[i] = '0;
		end
		repeat (3) @(posedge clk);
		rstN <= 1'b1;

		resetTest();
		aluTest();
		storeLoadTest();
		linkTest();
		stallFlushTest();
		haltFetchTest();
		repeat (2) @(posedge clk);

		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- flist.f
+incdir+include
source/isaPkg.sv
source/pipePkg.sv
source/exMemLatch.sv
source/memStage.sv
source/memWbLatch.sv
source/regFileWb.sv
source/memBackEnd.sv
tb/memBackEnd_chk.sv
tb/memBackEnd_tb.sv

//--- run.sh
#!/bin/sh
# build the back end testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f flist.f --top-module memBackEnd_tb -o memBackEndSim \
	&& ./obj_dir/memBackEndSim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "all tests passed" sim.log && exit 0 || exit 1
